//--- flist.f
+incdir+.
key_ntw_pkg.sv
key_bdc_if.sv
key_sync_fifo.sv
key_cmd_arbiter.sv
key_server.sv
key_client.sv
key_ntw_top.sv
tb_key_ntw_checker.sv
tb_key_ntw.sv

//--- Makefile
# Verilator build and run of the key distribution network testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_key_ntw
FLIST     = flist.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The run fails unless the log holds the pass line
run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_key_ntw.sv
// --------------------------------------------------------------------------
// Testbench top of the key distribution network. Clock, reset, key load,
// loop requests and ready patterns from an LFSR, run timeout.
// Comparison and the per-test report are left to the checker.
// --------------------------------------------------------------------------
`default_nettype none

`include "key_ntw_cfg.svh"

module tb_key_ntw;
  timeunit 1ns;
  timeprecision 1ps;
  import key_ntw_pkg::*;

  localparam int LOOP_NB     = `KEY_LOOP_NB;
  localparam int GROUP_NB    = `KEY_GROUP_NB;
  localparam int RST_CYCLES  = 16;
  localparam int PAIR_ROUNDS = 3;
  localparam int GAP_ROUNDS  = 6;
  localparam int STALL_NB    = 3;
  localparam int BURST_NB    = `KEY_CMD_DEPTH + 3;
  // Worst case command count over all tests
  localparam int CMD_TOTAL   = LOOP_NB + 2 * PAIR_ROUNDS + 2 * GAP_ROUNDS
                               + STALL_NB + BURST_NB;
  localparam int TIMEOUT_CYCLES = CMD_TOTAL * GROUP_NB * 4 + LOOP_NB * GROUP_NB
                                  + 2 * RST_CYCLES + 200;

  logic      clk;
  logic      s_rst_n;
  loop_t     cmd0_loop;
  logic      cmd0_avail;
  loop_t     cmd1_loop;
  logic      cmd1_avail;
  logic      wr_en;
  loop_t     wr_loop;
  group_t    wr_group;
  key_data_t wr_data;
  logic      key_vld;
  logic      key_rdy;
  loop_t     key_loop;
  group_t    key_group;
  key_data_t key_data;
  logic      cmd_ovf;
  logic      out_ovf;
  key_data_t model [LOOP_NB * GROUP_NB];
  logic [31:0] lfsr_q;
  logic      rdy_rand;
  int        cycle_cnt = 0;

  key_ntw_top dut_i (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .cmd0_loop_i  (cmd0_loop),
    .cmd0_avail_i (cmd0_avail),
    .cmd1_loop_i  (cmd1_loop),
    .cmd1_avail_i (cmd1_avail),
    .wr_en_i      (wr_en),
    .wr_loop_i    (wr_loop),
    .wr_group_i   (wr_group),
    .wr_data_i    (wr_data),
    .key_vld_o    (key_vld),
    .key_rdy_i    (key_rdy),
    .key_loop_o   (key_loop),
    .key_group_o  (key_group),
    .key_data_o   (key_data),
    .cmd_ovf_o    (cmd_ovf),
    .out_ovf_o    (out_ovf)
  );

  tb_key_ntw_checker chk_i (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .key_vld_i   (key_vld),
    .key_rdy_i   (key_rdy),
    .key_loop_i  (key_loop),
    .key_group_i (key_group),
    .key_data_i  (key_data),
    .cmd_ovf_i   (cmd_ovf),
    .out_ovf_i   (out_ovf),
    .model_i     (model)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Run stopped by timeout after %0d cycles", cycle_cnt);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Galois LFSR x^32 + x^22 + x^2 + x + 1 as random source
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  // Every input changes here on the falling edge
  task automatic tick();
    @(negedge clk);
    if (rdy_rand) key_rdy = (rand_bits(2) != '0);
  endtask

  task automatic apply_reset();
    s_rst_n = 1'b0;
    repeat (RST_CYCLES) tick();
    s_rst_n = 1'b1;
  endtask

  task automatic load_keys();
    for (int l = 0; l < LOOP_NB; l++) begin
      for (int g = 0; g < GROUP_NB; g++) begin
        tick();
        wr_en    = 1'b1;
        wr_loop  = loop_t'(l);
        wr_group = group_t'(g);
        wr_data  = rand_bits(64);
        model[{wr_loop, wr_group}] = wr_data;
      end
    end
    tick();
    wr_en = 1'b0;
  endtask

  task automatic strobe(input logic v0, input loop_t l0, input logic v1, input loop_t l1);
    tick();
    cmd0_avail = v0;
    cmd0_loop  = l0;
    cmd1_avail = v1;
    cmd1_loop  = l1;
  endtask

  task automatic release_cmds();
    tick();
    cmd0_avail = 1'b0;
    cmd1_avail = 1'b0;
  endtask

  // Until every expected word has left the DUT
  task automatic wait_drained();
    while (chk_i.words_left != 0 || key_vld) tick();
  endtask

  // Bounded waits for the sticky error flags
  task automatic wait_out_ovf(input int limit);
    for (int c = 0; c < limit && !out_ovf; c++) tick();
  endtask

  task automatic wait_cmd_ovf(input int limit);
    for (int c = 0; c < limit && !cmd_ovf; c++) tick();
  endtask

  initial begin
    loop_t la;
    loop_t lb;
    int    n;
    logic  req;
    clk        = 1'b0;
    s_rst_n    = 1'b0;
    cmd0_loop  = '0;
    cmd0_avail = 1'b0;
    cmd1_loop  = '0;
    cmd1_avail = 1'b0;
    wr_en      = 1'b0;
    wr_loop    = '0;
    wr_group   = '0;
    wr_data    = '0;
    key_rdy    = 1'b0;
    rdy_rand   = 1'b0;
    lfsr_q     = 32'h368b;
    apply_reset();
    load_keys();

    // Each loop once and one at a time
    chk_i.open_test("each loop from requester 0");
    key_rdy = 1'b1;
    for (int l = 0; l < LOOP_NB; l++) begin
      chk_i.expect_loop(loop_t'(l));
      strobe(1'b1, loop_t'(l), 1'b0, '0);
      release_cmds();
      wait_drained();
    end
    chk_i.close_test(1'b1, 1'b0, 1'b0);

    // Both requesters in one cycle with one loop per server
    chk_i.open_test("simultaneous requests");
    for (int r = 0; r < PAIR_ROUNDS; r++) begin
      la = loop_t'(rand_bits(2));
      lb = loop_t'(`KEY_SRV_LOOP_NB) + loop_t'(rand_bits(2));
      chk_i.expect_loop(la);
      chk_i.expect_loop(lb);
      strobe(1'b1, la, 1'b1, lb);
      release_cmds();
      wait_drained();
    end
    chk_i.close_test(1'b1, 1'b0, 1'b0);

    // Ready with random gaps and at most two loops in flight
    chk_i.open_test("ready gaps");
    rdy_rand = 1'b1;
    for (int r = 0; r < GAP_ROUNDS; r++) begin
      n = 1 + int'(rand_bits(1));
      for (int k = 0; k < n; k++) begin
        req = (rand_bits(1) != '0);
        la  = loop_t'(rand_bits(3));
        chk_i.expect_loop(la);
        if (req) strobe(1'b0, '0, 1'b1, la);
        else strobe(1'b1, la, 1'b0, '0);
      end
      release_cmds();
      wait_drained();
    end
    rdy_rand = 1'b0;
    chk_i.close_test(1'b1, 1'b0, 1'b0);

    // Stalled consumer gets 12 words for 8 entries
    chk_i.open_test("output overflow");
    key_rdy = 1'b0;
    for (int k = 0; k < STALL_NB; k++) strobe(1'b1, loop_t'(rand_bits(3)), 1'b0, '0);
    release_cmds();
    wait_out_ovf(STALL_NB * GROUP_NB * 4);
    chk_i.close_test(1'b0, 1'b1, 1'b0);

    // Command burst after a fresh reset
    apply_reset();
    chk_i.open_test("command overflow");
    chk_i.check_idle();
    key_rdy = 1'b1;
    for (int k = 0; k < BURST_NB; k++) strobe(1'b1, loop_t'(rand_bits(3)), 1'b0, '0);
    release_cmds();
    wait_cmd_ovf(BURST_NB * GROUP_NB * 4);
    chk_i.close_test(1'b0, 1'b0, 1'b1);

    chk_i.report();
    if (chk_i.err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_key_ntw_checker.sv
// --------------------------------------------------------------------------
// Testbench checker. Watches the consumer port of the key network,
// compares every transfer with the memory model and reports per test.
// The testbench top opens and closes each test through the tasks below.
// --------------------------------------------------------------------------
`default_nettype none

`include "key_ntw_cfg.svh"

module tb_key_ntw_checker (
  input  logic                   clk,
  input  logic                   s_rst_n,
  input  logic                   key_vld_i,
  input  logic                   key_rdy_i,
  input  key_ntw_pkg::loop_t     key_loop_i,
  input  key_ntw_pkg::group_t    key_group_i,
  input  key_ntw_pkg::key_data_t key_data_i,
  input  logic                   cmd_ovf_i,
  input  logic                   out_ovf_i,
  input  key_ntw_pkg::key_data_t model_i [`KEY_LOOP_NB * `KEY_GROUP_NB]
);
  timeunit 1ns;
  timeprecision 1ps;
  import key_ntw_pkg::*;

  localparam int     LOOP_NB    = `KEY_LOOP_NB;
  localparam int     GROUP_NB   = `KEY_GROUP_NB;
  localparam group_t LAST_GROUP = group_t'(GROUP_NB - 1);

  int     exp_cnt  [LOOP_NB];
  int     got_cnt  [LOOP_NB];
  group_t next_grp [LOOP_NB];
  int     test_num   = 0;
  int     test_err   = 0;
  int     test_words = 0;
  int     word_cnt   = 0;
  int     err_cnt    = 0;
  int     fail_tests = 0;
  int     words_left = 0;
  string  test_name;

  // Reference: the word the model holds for a tag
  function automatic key_data_t expected_word(input loop_t l, input group_t g);
    return model_i[{l, g}];
  endfunction

  task automatic count_error();
    test_err++;
    err_cnt++;
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      count_error();
    end
  endtask

  // --------------------------------------------------------------------------
  // Transfer check, one word per edge with valid and ready
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    if (s_rst_n && key_vld_i && key_rdy_i) begin
      word_cnt++;
      test_words++;
      if (words_left > 0) words_left--;
      if (key_data_i !== expected_word(key_loop_i, key_group_i)) begin
        $display("[FAIL] key_data_o loop %h group %h: got %h, expected %h",
                 key_loop_i, key_group_i, key_data_i,
                 expected_word(key_loop_i, key_group_i));
        count_error();
      end
      // Groups of one loop come in order
      if (key_group_i !== next_grp[key_loop_i]) begin
        $display("[FAIL] key_group_o loop %h: got %h, expected %h",
                 key_loop_i, key_group_i, next_grp[key_loop_i]);
        count_error();
      end
      if (key_group_i == LAST_GROUP) got_cnt[key_loop_i]++;
      next_grp[key_loop_i] = key_group_i + 1'b1;
    end
  end

  task automatic open_test(input string name);
    test_num++;
    test_name  = name;
    test_err   = 0;
    test_words = 0;
    words_left = 0;
    for (int l = 0; l < LOOP_NB; l++) begin
      exp_cnt[l]  = 0;
      got_cnt[l]  = 0;
      next_grp[l] = '0;
    end
  endtask

  task automatic expect_loop(input loop_t l);
    exp_cnt[l]++;
    words_left = words_left + GROUP_NB;
  endtask

  task automatic check_idle();
    compare_bit("key_vld_o", key_vld_i, 1'b0);
    compare_bit("cmd_ovf_o", cmd_ovf_i, 1'b0);
    compare_bit("out_ovf_o", out_ovf_i, 1'b0);
  endtask

  task automatic close_test(input bit counts_on, input logic out_ovf_exp,
                            input logic cmd_ovf_exp);
    compare_bit("out_ovf_o", out_ovf_i, out_ovf_exp);
    compare_bit("cmd_ovf_o", cmd_ovf_i, cmd_ovf_exp);
    if (counts_on) begin
      for (int l = 0; l < LOOP_NB; l++) begin
        if (got_cnt[l] != exp_cnt[l]) begin
          $display("Loop %0d was delivered %0d times instead of %0d",
                   l, got_cnt[l], exp_cnt[l]);
          count_error();
        end
        if (next_grp[l] != '0) begin
          $display("Loop %0d stopped after %0d of its words", l, next_grp[l]);
          count_error();
        end
      end
    end
    if (test_err == 0) begin
      $display("test %0d, %s: ok, %0d words", test_num, test_name, test_words);
    end else begin
      fail_tests++;
      $display("test %0d, %s: %0d errors, %0d words",
               test_num, test_name, test_err, test_words);
    end
  endtask

  task automatic report();
    $display("Tests run %0d, failed %0d, words checked %0d, errors %0d",
             test_num, fail_tests, word_cnt, err_cnt);
  endtask

endmodule

`default_nettype wire

//--- key_ntw_top.sv
// --------------------------------------------------------------------------
// Key distribution network top. Two key servers split the loops, the
// arbiter orders the loop requests and the client feeds the consumer.
// --------------------------------------------------------------------------
`default_nettype none

`include "key_ntw_cfg.svh"

module key_ntw_top (
  input  logic                   clk,
  input  logic                   s_rst_n,
  // Loop requests
  input  key_ntw_pkg::loop_t     cmd0_loop_i,
  input  logic                   cmd0_avail_i,
  input  key_ntw_pkg::loop_t     cmd1_loop_i,
  input  logic                   cmd1_avail_i,
  // Key memory load
  input  logic                   wr_en_i,
  input  key_ntw_pkg::loop_t     wr_loop_i,
  input  key_ntw_pkg::group_t    wr_group_i,
  input  key_ntw_pkg::key_data_t wr_data_i,
  // Consumer
  output logic                   key_vld_o,
  input  logic                   key_rdy_i,
  output key_ntw_pkg::loop_t     key_loop_o,
  output key_ntw_pkg::group_t    key_group_o,
  output key_ntw_pkg::key_data_t key_data_o,
  // Sticky errors
  output logic                   cmd_ovf_o,
  output logic                   out_ovf_o
);
  import key_ntw_pkg::*;

  loop_t issue_loop;
  logic  issue;

  key_bdc_if bdc0_if ();
  key_bdc_if bdc1_if ();

  // ------------------------------------------------------------------------
  // Servers, lower and upper loop range
  // ------------------------------------------------------------------------
  key_server #(
    .BR_LOOP_OFS (0),
    .BR_LOOP_NB  (`KEY_SRV_LOOP_NB)
  ) srv0_i (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .wr_en_i      (wr_en_i),
    .wr_loop_i    (wr_loop_i),
    .wr_group_i   (wr_group_i),
    .wr_data_i    (wr_data_i),
    .issue_i      (issue),
    .issue_loop_i (issue_loop),
    .bdc          (bdc0_if.source)
  );

  key_server #(
    .BR_LOOP_OFS (`KEY_SRV_LOOP_NB),
    .BR_LOOP_NB  (`KEY_SRV_LOOP_NB)
  ) srv1_i (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .wr_en_i      (wr_en_i),
    .wr_loop_i    (wr_loop_i),
    .wr_group_i   (wr_group_i),
    .wr_data_i    (wr_data_i),
    .issue_i      (issue),
    .issue_loop_i (issue_loop),
    .bdc          (bdc1_if.source)
  );

  key_cmd_arbiter arb_i (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .cmd0_loop_i  (cmd0_loop_i),
    .cmd0_avail_i (cmd0_avail_i),
    .cmd1_loop_i  (cmd1_loop_i),
    .cmd1_avail_i (cmd1_avail_i),
    .bdc0         (bdc0_if.sink),
    .bdc1         (bdc1_if.sink),
    .issue_loop_o (issue_loop),
    .issue_o      (issue),
    .cmd_ovf_o    (cmd_ovf_o)
  );

  key_client clt_i (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .bdc0        (bdc0_if.sink),
    .bdc1        (bdc1_if.sink),
    .key_vld_o   (key_vld_o),
    .key_rdy_i   (key_rdy_i),
    .key_loop_o  (key_loop_o),
    .key_group_o (key_group_o),
    .key_data_o  (key_data_o),
    .out_ovf_o   (out_ovf_o)
  );

endmodule

`default_nettype wire

//--- key_client.sv
// --------------------------------------------------------------------------
// Key client. Merges the two server broadcasts, buffers the tagged words
// and hands them to the NTT consumer with valid/ready.
// --------------------------------------------------------------------------
`default_nettype none

`include "key_ntw_cfg.svh"

module key_client (
  input  logic                   clk,
  input  logic                   s_rst_n,
  key_bdc_if.sink                bdc0,
  key_bdc_if.sink                bdc1,
  output logic                   key_vld_o,
  input  logic                   key_rdy_i,
  output key_ntw_pkg::loop_t     key_loop_o,
  output key_ntw_pkg::group_t    key_group_o,
  output key_ntw_pkg::key_data_t key_data_o,
  output logic                   out_ovf_o
);
  import key_ntw_pkg::*;

  key_word_t merged;
  logic      merged_avail;
  key_word_t head;
  logic      fifo_wr;
  logic      fifo_rd;
  logic      fifo_empty;
  logic      fifo_full;
  logic      drop;

  // ------------------------------------------------------------------------
  // Merge
  // ------------------------------------------------------------------------
  // Idle servers drive zeros, only one talks at a time
  assign merged_avail = bdc0.avail | bdc1.avail;
  assign merged.loop  = bdc0.loop | bdc1.loop;
  assign merged.group = bdc0.group | bdc1.group;
  assign merged.data  = bdc0.data | bdc1.data;

  // ------------------------------------------------------------------------
  // Output buffer
  // ------------------------------------------------------------------------
  assign fifo_rd = key_rdy_i & ~fifo_empty;
  assign fifo_wr = merged_avail & (~fifo_full | fifo_rd);
  // Servers never stall, a full buffer loses the word
  assign drop    = merged_avail & fifo_full & ~fifo_rd;

  key_sync_fifo #(
    .T     (key_word_t),
    .DEPTH (`KEY_OUT_DEPTH)
  ) out_fifo_i (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .wr_i    (fifo_wr),
    .wdata_i (merged),
    .rd_i    (fifo_rd),
    .rdata_o (head),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

  assign key_vld_o   = ~fifo_empty;
  assign key_loop_o  = head.loop;
  assign key_group_o = head.group;
  assign key_data_o  = head.data;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      out_ovf_o <= 1'b0;
    end else begin
      out_ovf_o <= out_ovf_o | drop;
    end
  end

  a_one_server : assert property (@(posedge clk) disable iff (!s_rst_n)
    !(bdc0.avail && bdc1.avail));

endmodule

`default_nettype wire

//--- key_server.sv
// --------------------------------------------------------------------------
// Key server for one range of loops. Holds the key words of its loops,
// loaded through the write port, and broadcasts all groups of a loop
// when the arbiter issues a loop inside its range.
// --------------------------------------------------------------------------
`default_nettype none

`include "key_ntw_cfg.svh"

module key_server #(
  parameter int BR_LOOP_OFS = 0,
  parameter int BR_LOOP_NB  = 4
) (
  input  logic                  clk,
  input  logic                  s_rst_n,
  input  logic                  wr_en_i,
  input  key_ntw_pkg::loop_t    wr_loop_i,
  input  key_ntw_pkg::group_t   wr_group_i,
  input  key_ntw_pkg::key_data_t wr_data_i,
  input  logic                  issue_i,
  input  key_ntw_pkg::loop_t    issue_loop_i,
  key_bdc_if.source             bdc
);
  import key_ntw_pkg::*;

  localparam int     RAM_DEPTH  = BR_LOOP_NB * `KEY_GROUP_NB;
  localparam int     ADD_W      = $clog2(RAM_DEPTH);
  localparam int     LAT        = `KEY_RAM_LATENCY;
  localparam group_t LAST_GROUP = group_t'(`KEY_GROUP_NB - 1);

  key_data_t        mem [RAM_DEPTH];
  logic             accept;
  logic             run_q;
  group_t           cnt_q;
  loop_t            cur_loop_q;
  logic             busy_q;
  logic [LAT-1:0]   rd_vld_q;
  key_data_t        rd_data_q  [LAT];
  loop_t            rd_loop_q  [LAT];
  group_t           rd_group_q [LAT];
  logic             last_out;

  function automatic logic own_loop(loop_t l);
    return (int'(l) >= BR_LOOP_OFS) && (int'(l) < BR_LOOP_OFS + BR_LOOP_NB);
  endfunction

  // Local loop major, group minor
  function automatic logic [ADD_W-1:0] ram_add(loop_t l, group_t g);
    return ADD_W'((int'(l) - BR_LOOP_OFS) * `KEY_GROUP_NB + int'(g));
  endfunction

  // ------------------------------------------------------------------------
  // Write decode
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en_i && own_loop(wr_loop_i)) mem[ram_add(wr_loop_i, wr_group_i)] <= wr_data_i;
  end

  // ------------------------------------------------------------------------
  // Read sequencer
  // ------------------------------------------------------------------------
  assign accept   = issue_i & own_loop(issue_loop_i);
  assign last_out = rd_vld_q[LAT-1] && (rd_group_q[LAT-1] == LAST_GROUP);

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      run_q    <= 1'b0;
      cnt_q    <= '0;
      busy_q   <= 1'b0;
      rd_vld_q <= '0;
    end else begin
      if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == LAST_GROUP) run_q <= 1'b0;
      end
      // Busy ends with the last word on the bus
      if (last_out) busy_q <= 1'b0;
      if (accept) begin
        run_q  <= 1'b1;
        cnt_q  <= '0;
        busy_q <= 1'b1;
      end
      rd_vld_q[0] <= run_q;
      for (int i = 1; i < LAT; i++) rd_vld_q[i] <= rd_vld_q[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (accept) cur_loop_q <= issue_loop_i;
  end

  // Memory read and tag pipeline
  always_ff @(posedge clk) begin
    rd_data_q[0]  <= mem[ram_add(cur_loop_q, cnt_q)];
    rd_loop_q[0]  <= cur_loop_q;
    rd_group_q[0] <= cnt_q;
    for (int i = 1; i < LAT; i++) begin
      rd_data_q[i]  <= rd_data_q[i-1];
      rd_loop_q[i]  <= rd_loop_q[i-1];
      rd_group_q[i] <= rd_group_q[i-1];
    end
  end

  // Zero outside avail so the client can OR both servers
  assign bdc.avail = rd_vld_q[LAT-1];
  assign bdc.data  = rd_vld_q[LAT-1] ? rd_data_q[LAT-1] : '0;
  assign bdc.loop  = rd_vld_q[LAT-1] ? rd_loop_q[LAT-1] : '0;
  assign bdc.group = rd_vld_q[LAT-1] ? rd_group_q[LAT-1] : '0;
  assign bdc.busy  = busy_q;

  a_avail_in_busy : assert property (@(posedge clk) disable iff (!s_rst_n)
    bdc.avail |-> bdc.busy);

endmodule

`default_nettype wire

//--- key_cmd_arbiter.sv
// --------------------------------------------------------------------------
// Command arbiter. Captures loop requests of two requesters into a FIFO,
// round-robin when both strobe together, and issues the head to the
// servers once neither of them is broadcasting.
// --------------------------------------------------------------------------
`default_nettype none

`include "key_ntw_cfg.svh"

module key_cmd_arbiter (
  input  logic               clk,
  input  logic               s_rst_n,
  input  key_ntw_pkg::loop_t cmd0_loop_i,
  input  logic               cmd0_avail_i,
  input  key_ntw_pkg::loop_t cmd1_loop_i,
  input  logic               cmd1_avail_i,
  key_bdc_if.sink            bdc0,
  key_bdc_if.sink            bdc1,
  output key_ntw_pkg::loop_t issue_loop_o,
  output logic               issue_o,
  output logic               cmd_ovf_o
);
  import key_ntw_pkg::*;

  logic  rr_q;
  logic  stage_vld_q;
  loop_t stage_loop_q;
  logic  stage_vld_d;
  loop_t stage_loop_d;
  logic  both;
  loop_t first_loop;
  loop_t second_loop;
  logic  fifo_req;
  logic  fifo_wr;
  logic  fifo_rd;
  loop_t fifo_wdata;
  loop_t fifo_head;
  logic  fifo_empty;
  logic  fifo_full;
  logic  fifo_drop;
  logic  issue_go;

  // ------------------------------------------------------------------------
  // Capture
  // ------------------------------------------------------------------------
  assign both = cmd0_avail_i & cmd1_avail_i;

  // rr_q set gives requester 1 the first slot
  assign first_loop  = (cmd1_avail_i && (!cmd0_avail_i || rr_q)) ? cmd1_loop_i : cmd0_loop_i;
  assign second_loop = rr_q ? cmd0_loop_i : cmd1_loop_i;

  // A staged command is older, so it is written first
  assign fifo_req     = stage_vld_q | cmd0_avail_i | cmd1_avail_i;
  assign fifo_wdata   = stage_vld_q ? stage_loop_q : first_loop;
  assign fifo_wr      = fifo_req & (~fifo_full | fifo_rd);
  assign stage_vld_d  = stage_vld_q ? (cmd0_avail_i | cmd1_avail_i) : both;
  assign stage_loop_d = stage_vld_q ? first_loop : second_loop;

  // Lost when the FIFO is full, or three commands compete for two slots
  assign fifo_drop = (fifo_req & fifo_full & ~fifo_rd) | (stage_vld_q & both);

  // ------------------------------------------------------------------------
  // Issue
  // ------------------------------------------------------------------------
  // Busy rises one edge after issue, hence the gap after each issue
  assign issue_go = ~fifo_empty & ~bdc0.busy & ~bdc1.busy & ~issue_o;
  assign fifo_rd  = issue_go;

  key_sync_fifo #(
    .T     (loop_t),
    .DEPTH (`KEY_CMD_DEPTH)
  ) cmd_fifo_i (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .wr_i    (fifo_wr),
    .wdata_i (fifo_wdata),
    .rd_i    (fifo_rd),
    .rdata_o (fifo_head),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      rr_q        <= 1'b0;
      stage_vld_q <= 1'b0;
      issue_o     <= 1'b0;
      cmd_ovf_o   <= 1'b0;
    end else begin
      rr_q        <= rr_q ^ both;
      stage_vld_q <= stage_vld_d;
      issue_o     <= issue_go;
      cmd_ovf_o   <= cmd_ovf_o | fifo_drop;
    end
  end

  always_ff @(posedge clk) begin
    stage_loop_q <= stage_loop_d;
    if (issue_go) issue_loop_o <= fifo_head;
  end

  a_issue_idle : assert property (@(posedge clk) disable iff (!s_rst_n)
    $rose(issue_o) |-> !bdc0.busy && !bdc1.busy);

endmodule

`default_nettype wire

//--- key_sync_fifo.sv
// --------------------------------------------------------------------------
// Synchronous FIFO for any payload type. The head entry is always shown
// on rdata_o; rd_i pops it. Used for commands and for key words.
// --------------------------------------------------------------------------
`default_nettype none

module key_sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic s_rst_n,
  input  logic wr_i,
  input  T     wdata_i,
  input  logic rd_i,
  output T     rdata_o,
  output logic empty_o,
  output logic full_o
);

  localparam int AW = $clog2(DEPTH);

  T               mem [DEPTH];
  logic [AW-1:0]  wr_ptr_q;
  logic [AW-1:0]  rd_ptr_q;
  logic [AW:0]    count_q;

  assign rdata_o = mem[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (AW+1)'(DEPTH));

  always_ff @(posedge clk) begin
    if (wr_i) mem[wr_ptr_q] <= wdata_i;
  end

  // Pointers and fill level
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_i) wr_ptr_q <= (wr_ptr_q == AW'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      if (rd_i) rd_ptr_q <= (rd_ptr_q == AW'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + (AW+1)'(wr_i) - (AW+1)'(rd_i);
    end
  end

  a_no_wr_full : assert property (@(posedge clk) disable iff (!s_rst_n)
    !(wr_i && full_o && !rd_i));

  a_no_rd_empty : assert property (@(posedge clk) disable iff (!s_rst_n)
    !(rd_i && empty_o));

endmodule

`default_nettype wire

//--- key_bdc_if.sv
// --------------------------------------------------------------------------
// Broadcast bus of one key server. The server drives the source side,
// the client and the command arbiter listen on the sink side.
// --------------------------------------------------------------------------
`default_nettype none

interface key_bdc_if;
  import key_ntw_pkg::*;

  // Key word, zero when avail is low
  key_data_t data;
  // One-cycle strobe per word
  logic      avail;
  loop_t     loop;
  group_t    group;
  // High from command acceptance to the last word
  logic      busy;

  modport source (
    output data,
    output avail,
    output loop,
    output group,
    output busy
  );

  modport sink (
    input data,
    input avail,
    input loop,
    input group,
    input busy
  );

endinterface

`default_nettype wire

//--- key_ntw_pkg.sv
// --------------------------------------------------------------------------
// Types shared by the key distribution network: loop and group indexes,
// the raw key word and the tagged key word stored in the client FIFO.
// --------------------------------------------------------------------------
`default_nettype none

`include "key_ntw_cfg.svh"

package key_ntw_pkg;

  localparam int LOOP_W  = $clog2(`KEY_LOOP_NB);
  localparam int GROUP_W = $clog2(`KEY_GROUP_NB);
  localparam int DATA_W  = `KEY_COEF_NB * `KEY_OP_W;

  // Blind-rotation loop index
  typedef logic [LOOP_W-1:0] loop_t;

  // Group index inside one loop
  typedef logic [GROUP_W-1:0] group_t;

  // One key word, all coefficients side by side
  typedef logic [DATA_W-1:0] key_data_t;

  // ------------------------------------------------------------------------
  // Tagged word toward the consumer
  // ------------------------------------------------------------------------
  typedef struct packed {
    loop_t     loop;
    group_t    group;
    key_data_t data;
  } key_word_t;

endpackage

`default_nettype wire

//--- key_ntw_cfg.svh
// --------------------------------------------------------------------------
// Sizes and latencies of the key distribution network.
// Included by the package and by every module that needs a size.
// --------------------------------------------------------------------------
`ifndef KEY_NTW_CFG_SVH
`define KEY_NTW_CFG_SVH

// Coefficient width in bits
`define KEY_OP_W 16

// Coefficients carried by one key word
`define KEY_COEF_NB 4

// Key words (groups) per blind-rotation loop
`define KEY_GROUP_NB 4

// Loops held by each server
`define KEY_SRV_LOOP_NB 4

// Loops over the whole network
`define KEY_LOOP_NB 8

// Key memory read latency in cycles
`define KEY_RAM_LATENCY 1

// FIFO depths
`define KEY_CMD_DEPTH 4
`define KEY_OUT_DEPTH 8

`endif
